//--- src/sys_ctrl_pkg.sv
package sys_ctrl_pkg;

  // register map of the monitor bus
  localparam logic [2:0] REG_CTRL    = 3'd0;
  localparam logic [2:0] REG_STATUS  = 3'd1;
  localparam logic [2:0] REG_DIP     = 3'd2;
  localparam logic [2:0] REG_SYSCFG  = 3'd3;
  localparam logic [2:0] REG_SCRATCH = 3'd4;

  // control byte, boot_start and abort act as one-shot commands
  typedef struct packed {
    logic       boot_start;  // bit 7
    logic       abort;       // bit 6
    logic       eeprom_wp;   // bit 5
    logic [1:0] user_led;    // bits 4..3
    logic       por_force;   // bit 2
    logic       init_drive;  // bit 1, pull init low
    logic       prog;        // bit 0, hold program asserted
  } ctrl_fields_t;

  typedef union packed {
    logic [7:0]   raw;
    ctrl_fields_t ctl;
  } ctrl_word_u;

  // defaults for the top level parameters
  localparam int DEF_PROG_CYCLES = 4;
  localparam int DEF_CCLK_HALF   = 2;
  localparam int DEF_HB_BIT      = 5;

endpackage

//--- src/cfg_if.sv
`timescale 1ns/1ns

// configuration pin bundle of the main FPGA
interface cfg_if;
  logic prog_n;    // program pin, active low
  logic init_low;  // pull init pin low
  logic din;       // serial data
  logic cclk;      // configuration clock
  logic busy;      // source is running a load

  modport src (
    output prog_n,
    output init_low,
    output din,
    output cclk,
    output busy
  );

  modport snk (
    input prog_n,
    input init_low,
    input din,
    input cclk,
    input busy
  );
endinterface

//--- src/reg_bank.sv
`timescale 1ns/1ns

module reg_bank (
  input  logic       clk_master,
  input  logic       reset_mon,
  input  logic       bus_stb_i,
  input  logic       bus_we_i,
  input  logic [2:0] bus_adr_i,
  input  logic [7:0] bus_dat_i,
  output logic [7:0] bus_dat_o,
  output logic       bus_ack_o,
  input  logic [3:0] user_dip_i,
  input  logic [3:0] config_dip_i,
  input  logic [7:0] sys_config_i,
  input  logic       flash_busy_n_i,
  input  logic       cfg_init_n_i,
  input  logic       cfg_done_i,
  input  logic       busy_i,
  output logic       start_o,
  output logic       abort_o,
  output logic       eeprom_wp_o,
  output logic [1:0] user_led_o,
  output logic       por_force_o,
  cfg_if.src         cfg_reg
);

  sys_ctrl_pkg::ctrl_word_u ctrl_q;   // stored control bits
  sys_ctrl_pkg::ctrl_word_u wr_word;  // incoming byte split into fields
  logic [7:0] scratch_q;
  logic [7:0] rd_data;
  logic       access;                 // first sampled cycle of a strobe
  logic       wr_ctrl;
  logic       wr_scratch;

  assign access     = bus_stb_i & ~bus_ack_o;
  assign wr_ctrl    = access & bus_we_i & (bus_adr_i == sys_ctrl_pkg::REG_CTRL);
  assign wr_scratch = access & bus_we_i & (bus_adr_i == sys_ctrl_pkg::REG_SCRATCH);

  always_comb begin
    wr_word.raw = bus_dat_i;
  end

  // read mux, unmapped addresses give zero
  always_comb begin
    case (bus_adr_i)
      sys_ctrl_pkg::REG_CTRL:    rd_data = ctrl_q.raw;
      sys_ctrl_pkg::REG_STATUS:  rd_data = {4'b0000, ~flash_busy_n_i, busy_i,
                                            cfg_done_i, cfg_init_n_i};
      sys_ctrl_pkg::REG_DIP:     rd_data = {config_dip_i, user_dip_i};
      sys_ctrl_pkg::REG_SYSCFG:  rd_data = sys_config_i;
      sys_ctrl_pkg::REG_SCRATCH: rd_data = scratch_q;
      default:                   rd_data = 8'h00;
    endcase
  end

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      ctrl_q.raw <= 8'h00;
      scratch_q  <= 8'h00;
      bus_ack_o  <= 1'b0;
      bus_dat_o  <= 8'h00;
      start_o    <= 1'b0;
      abort_o    <= 1'b0;
    end else begin
      bus_ack_o <= access;                       // ack one cycle after the strobe
      bus_dat_o <= (access & ~bus_we_i) ? rd_data : 8'h00;
      start_o   <= wr_ctrl & wr_word.ctl.boot_start;
      abort_o   <= wr_ctrl & wr_word.ctl.abort;
      if (wr_ctrl) begin
        // command bits are not kept, they read back as zero
        ctrl_q.ctl.prog       <= wr_word.ctl.prog;
        ctrl_q.ctl.init_drive <= wr_word.ctl.init_drive;
        ctrl_q.ctl.por_force  <= wr_word.ctl.por_force;
        ctrl_q.ctl.user_led   <= wr_word.ctl.user_led;
        ctrl_q.ctl.eeprom_wp  <= wr_word.ctl.eeprom_wp;
      end
      if (wr_scratch) begin
        scratch_q <= bus_dat_i;
      end
    end
  end

  assign eeprom_wp_o = user_dip_i[3] | ctrl_q.ctl.eeprom_wp;  // dip switch forces protect
  assign user_led_o  = ctrl_q.ctl.user_led;
  assign por_force_o = ctrl_q.ctl.por_force;

  // manual pin control when the loader is idle
  assign cfg_reg.prog_n   = ~ctrl_q.ctl.prog;
  assign cfg_reg.init_low = ctrl_q.ctl.init_drive;
  assign cfg_reg.din      = 1'b0;
  assign cfg_reg.cclk     = 1'b1;  // parked high
  assign cfg_reg.busy     = 1'b0;

  // single-cycle acknowledge per transfer
  ack_single: assert property (
    @(posedge clk_master) disable iff (reset_mon)
    bus_ack_o |=> !bus_ack_o
  );

endmodule

//--- src/serial_loader.sv
`timescale 1ns/1ns

module serial_loader #(
  parameter int PROG_CYCLES = sys_ctrl_pkg::DEF_PROG_CYCLES,
  parameter int CCLK_HALF   = sys_ctrl_pkg::DEF_CCLK_HALF
) (
  input  logic       clk_master,
  input  logic       reset_mon,
  input  logic       start_i,
  input  logic       abort_i,
  input  logic [7:0] boot_data_i,
  input  logic       boot_strb_i,
  output logic       boot_rdy_o,
  input  logic       cfg_init_n_i,
  input  logic       cfg_done_i,
  cfg_if.src         cfg_ld
);

  localparam int CNT_MAX = (PROG_CYCLES > CCLK_HALF) ? PROG_CYCLES : CCLK_HALF;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);
  localparam logic [CNT_W-1:0] PROG_LOAD = CNT_W'(PROG_CYCLES - 1);
  localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(CCLK_HALF - 1);

  localparam logic [2:0] S_IDLE      = 3'd0;
  localparam logic [2:0] S_PROG      = 3'd1;
  localparam logic [2:0] S_INIT      = 3'd2;  // wait for init_n high
  localparam logic [2:0] S_BYTE_WAIT = 3'd3;
  localparam logic [2:0] S_SHIFT     = 3'd4;

  logic [2:0]       state_q;
  logic [CNT_W-1:0] cnt_q;     // program pulse and half period timer
  logic [2:0]       bit_q;     // bits left after the current one
  logic [7:0]       shift_q;
  logic             busy_q;
  logic             prog_n_q;
  logic             din_q;
  logic             cclk_q;
  logic             rdy_q;
  logic             cnt_zero;
  logic             load_byte;
  logic             next_bit;

  assign cnt_zero  = (cnt_q == '0);
  assign load_byte = (state_q == S_BYTE_WAIT) & boot_strb_i & ~cfg_done_i;
  assign next_bit  = (state_q == S_SHIFT) & cnt_zero & cclk_q & (bit_q != 3'd0);

  always_ff @(posedge clk_master) begin
    if (load_byte) begin
      shift_q <= boot_data_i;
    end else if (next_bit) begin
      shift_q <= {shift_q[6:0], 1'b0};  // msb first
    end
  end

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      state_q  <= S_IDLE;
      cnt_q    <= '0;
      bit_q    <= 3'd0;
      busy_q   <= 1'b0;
      prog_n_q <= 1'b1;
      din_q    <= 1'b0;
      cclk_q   <= 1'b1;
      rdy_q    <= 1'b0;
    end else if (abort_i) begin
      state_q  <= S_IDLE;
      busy_q   <= 1'b0;
      prog_n_q <= 1'b1;
      cclk_q   <= 1'b1;
      rdy_q    <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            state_q  <= S_PROG;
            busy_q   <= 1'b1;
            prog_n_q <= 1'b0;
            cnt_q    <= PROG_LOAD;
          end
        end
        S_PROG: begin
          if (cnt_zero) begin
            prog_n_q <= 1'b1;
            state_q  <= S_INIT;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        S_INIT: begin
          if (cfg_init_n_i) begin
            rdy_q   <= 1'b1;
            state_q <= S_BYTE_WAIT;
          end
        end
        S_BYTE_WAIT: begin
          if (cfg_done_i) begin
            state_q <= S_IDLE;
            busy_q  <= 1'b0;
            rdy_q   <= 1'b0;
          end else if (load_byte) begin
            rdy_q   <= 1'b0;
            cclk_q  <= 1'b0;
            din_q   <= boot_data_i[7];
            bit_q   <= 3'd7;
            cnt_q   <= HALF_LOAD;
            state_q <= S_SHIFT;
          end
        end
        S_SHIFT: begin
          if (!cnt_zero) begin
            cnt_q <= cnt_q - 1'b1;
          end else if (!cclk_q) begin
            cclk_q <= 1'b1;   // rising edge, device samples din
            cnt_q  <= HALF_LOAD;
          end else if (next_bit) begin
            cclk_q <= 1'b0;
            din_q  <= shift_q[6];
            bit_q  <= bit_q - 1'b1;
            cnt_q  <= HALF_LOAD;
          end else if (cfg_done_i) begin
            state_q <= S_IDLE;
            busy_q  <= 1'b0;
          end else begin
            rdy_q   <= 1'b1;  // byte boundary
            state_q <= S_BYTE_WAIT;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign boot_rdy_o      = rdy_q;
  assign cfg_ld.prog_n   = prog_n_q;
  assign cfg_ld.init_low = 1'b0;     // loader only watches init
  assign cfg_ld.din      = din_q;
  assign cfg_ld.cclk     = cclk_q;
  assign cfg_ld.busy     = busy_q;

  cclk_idle_high: assert property (
    @(posedge clk_master) disable iff (reset_mon)
    !busy_q |-> cclk_q
  );

endmodule

//--- src/cfg_combiner.sv
`timescale 1ns/1ns

module cfg_combiner #(
  parameter int HB_BIT = sys_ctrl_pkg::DEF_HB_BIT
) (
  input  logic       clk_master,
  input  logic       reset_mon,
  cfg_if.snk         cfg_ld,
  cfg_if.snk         cfg_reg,
  input  logic       por_force_i,
  input  logic [1:0] user_led_i,
  output logic       cfg_prog_n_o,
  output logic       cfg_init_low_o,
  output logic       cfg_din_o,
  output logic       cfg_cclk_o,
  output logic       por_force_n_o,
  output logic [1:0] sys_led_n_o,
  output logic [1:0] user_led_n_o
);

  logic            ld_sel;     // loader owns the pins
  logic            any_busy;
  logic            por_prev_q;
  logic [HB_BIT:0] hb_cnt_q;   // heartbeat

  assign ld_sel   = cfg_ld.busy;
  assign any_busy = cfg_ld.busy | cfg_reg.busy;

  // pin mux, registered
  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      cfg_prog_n_o   <= 1'b1;
      cfg_init_low_o <= 1'b0;
      cfg_din_o      <= 1'b0;
      cfg_cclk_o     <= 1'b1;
    end else if (ld_sel) begin
      cfg_prog_n_o   <= cfg_ld.prog_n;
      cfg_init_low_o <= cfg_ld.init_low;
      cfg_din_o      <= cfg_ld.din;
      cfg_cclk_o     <= cfg_ld.cclk;
    end else begin
      cfg_prog_n_o   <= cfg_reg.prog_n;
      cfg_init_low_o <= cfg_reg.init_low;
      cfg_din_o      <= cfg_reg.din;
      cfg_cclk_o     <= cfg_reg.cclk;
    end
  end

  // reset force is sticky until the next monitor reset
  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      por_prev_q    <= 1'b0;
      por_force_n_o <= 1'b1;
    end else begin
      por_prev_q <= por_force_i;
      if (por_force_i && !por_prev_q) begin
        por_force_n_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_master) begin
    if (reset_mon) begin
      hb_cnt_q     <= '0;
      sys_led_n_o  <= 2'b11;
      user_led_n_o <= 2'b11;
    end else begin
      hb_cnt_q     <= hb_cnt_q + 1'b1;
      sys_led_n_o  <= {~any_busy, hb_cnt_q[HB_BIT]};
      user_led_n_o <= {~(user_led_i[1] | any_busy), ~user_led_i[0]};  // leds are active low
    end
  end

  // loader clock reaches the pin unchanged, one register later
  cclk_follows_loader: assert property (
    @(posedge clk_master) disable iff (reset_mon)
    $past(cfg_ld.busy) |-> (cfg_cclk_o == $past(cfg_ld.cclk))
  );

endmodule

//--- src/sys_ctrl_top.sv
`timescale 1ns/1ns

module sys_ctrl_top #(
  parameter int PROG_CYCLES = sys_ctrl_pkg::DEF_PROG_CYCLES,
  parameter int CCLK_HALF   = sys_ctrl_pkg::DEF_CCLK_HALF,
  parameter int HB_BIT      = sys_ctrl_pkg::DEF_HB_BIT
) (
  input  logic       clk_master,
  input  logic       reset_mon,
  input  logic       bus_stb_i,
  input  logic       bus_we_i,
  input  logic [2:0] bus_adr_i,
  input  logic [7:0] bus_dat_i,
  output logic [7:0] bus_dat_o,
  output logic       bus_ack_o,
  input  logic [7:0] boot_data_i,
  input  logic       boot_strb_i,
  output logic       boot_rdy_o,
  output logic       cfg_prog_n_o,
  output logic       cfg_init_low_o,
  output logic       cfg_din_o,
  output logic       cfg_cclk_o,
  input  logic       cfg_init_n_i,
  input  logic       cfg_done_i,
  input  logic [3:0] user_dip_i,
  input  logic [3:0] config_dip_i,
  input  logic [7:0] sys_config_i,
  input  logic       flash_busy_n_i,
  output logic       por_force_n_o,
  output logic       eeprom_wp_o,
  output logic [1:0] sys_led_n_o,
  output logic [1:0] user_led_n_o
);

  cfg_if cfg_ld ();   // driven by the serial loader
  cfg_if cfg_reg ();  // driven by the control register

  logic       ld_start;
  logic       ld_abort;
  logic       por_force;
  logic [1:0] user_led;

  reg_bank i_reg_bank (
    .clk_master, .reset_mon,
    .bus_stb_i, .bus_we_i, .bus_adr_i, .bus_dat_i, .bus_dat_o, .bus_ack_o,
    .user_dip_i, .config_dip_i, .sys_config_i, .flash_busy_n_i,
    .cfg_init_n_i, .cfg_done_i,
    .busy_i(cfg_ld.busy), .start_o(ld_start), .abort_o(ld_abort),
    .eeprom_wp_o, .user_led_o(user_led), .por_force_o(por_force),
    .cfg_reg(cfg_reg)
  );

  serial_loader #(.PROG_CYCLES(PROG_CYCLES), .CCLK_HALF(CCLK_HALF)) i_serial_loader (
    .clk_master, .reset_mon,
    .start_i(ld_start), .abort_i(ld_abort),
    .boot_data_i, .boot_strb_i, .boot_rdy_o,
    .cfg_init_n_i, .cfg_done_i,
    .cfg_ld(cfg_ld)
  );

  cfg_combiner #(.HB_BIT(HB_BIT)) i_cfg_combiner (
    .clk_master, .reset_mon,
    .cfg_ld(cfg_ld), .cfg_reg(cfg_reg),
    .por_force_i(por_force), .user_led_i(user_led),
    .cfg_prog_n_o, .cfg_init_low_o, .cfg_din_o, .cfg_cclk_o,
    .por_force_n_o, .sys_led_n_o, .user_led_n_o
  );

endmodule

//--- tests/tb_sys_ctrl.sv
`timescale 1ns/1ns

module tb_sys_ctrl;

  localparam int CCLK_HALF  = sys_ctrl_pkg::DEF_CCLK_HALF;
  localparam int HB_BIT     = sys_ctrl_pkg::DEF_HB_BIT;
  localparam int N_TESTS    = 6;
  localparam int N_BYTES    = 6;
  localparam int WD_CYCLES  = N_TESTS * N_BYTES * 16 * CCLK_HALF + 2000;
  localparam int WAIT_LIMIT = 400;

  logic clk_master, reset_mon, bus_stb, bus_we, bus_ack, boot_strb, boot_rdy;
  logic cfg_prog_n, cfg_init_low, cfg_din, cfg_cclk, cfg_init_n, cfg_done;
  logic flash_busy_n, por_force_n, eeprom_wp, exp_busy, cclk_prev;
  logic [1:0] sys_led_n, user_led_n;
  logic [2:0] bus_adr;
  logic [3:0] user_dip, config_dip;
  logic [7:0] bus_dat_w, bus_dat_r, boot_data, sys_config, ctrl_sh, scratch_sh;
  logic [31:0] rng_state = 32'hb23c48f0;  // xorshift state
  logic       rx_bits[$];                // bits seen on the config port
  logic [7:0] stream[$];
  int done_after;                        // device reports done after this many bytes
  int init_wait;

  sys_ctrl_top i_dut (
    .clk_master, .reset_mon,
    .bus_stb_i(bus_stb), .bus_we_i(bus_we), .bus_adr_i(bus_adr), .bus_dat_i(bus_dat_w),
    .bus_dat_o(bus_dat_r), .bus_ack_o(bus_ack),
    .boot_data_i(boot_data), .boot_strb_i(boot_strb), .boot_rdy_o(boot_rdy),
    .cfg_prog_n_o(cfg_prog_n), .cfg_init_low_o(cfg_init_low), .cfg_din_o(cfg_din),
    .cfg_cclk_o(cfg_cclk), .cfg_init_n_i(cfg_init_n), .cfg_done_i(cfg_done),
    .user_dip_i(user_dip), .config_dip_i(config_dip), .sys_config_i(sys_config),
    .flash_busy_n_i(flash_busy_n), .por_force_n_o(por_force_n), .eeprom_wp_o(eeprom_wp),
    .sys_led_n_o(sys_led_n), .user_led_n_o(user_led_n)
  );

  initial begin
    clk_master = 1'b0;
    forever #50 clk_master = ~clk_master;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // expected read data from the shadow registers and the driven pins
  function automatic logic [7:0] ref_read(input logic [2:0] adr);
    case (adr)
      sys_ctrl_pkg::REG_CTRL:    return ctrl_sh;
      sys_ctrl_pkg::REG_STATUS:  return {4'b0000, ~flash_busy_n, exp_busy, cfg_done, cfg_init_n};
      sys_ctrl_pkg::REG_DIP:     return {config_dip, user_dip};
      sys_ctrl_pkg::REG_SYSCFG:  return sys_config;
      sys_ctrl_pkg::REG_SCRATCH: return scratch_sh;
      default:                   return 8'h00;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic apply_reset();
    reset_mon = 1'b1;
    repeat (2) @(posedge clk_master);
    #10;
    reset_mon  = 1'b0;
    ctrl_sh    = 8'h00;
    scratch_sh = 8'h00;
    exp_busy   = 1'b0;
  endtask

  // one bus cycle that starts and ends 10 ns after a rising edge
  task automatic bus_xfer(input logic we, input logic [2:0] adr, input logic [7:0] dat,
                          output logic [7:0] rd);
    int n;
    n = 0;
    {bus_stb, bus_we, bus_adr, bus_dat_w} = {1'b1, we, adr, dat};
    do begin
      @(posedge clk_master);
      #10;
      n++;
    end while (!bus_ack && n < 8);
    check_val("bus ack latency", 1, n);
    rd = bus_dat_r;  // valid in the ack cycle
    @(posedge clk_master);
    #10;
    {bus_stb, bus_we} = 2'b00;
  endtask

  task automatic reg_write(input logic [2:0] adr, input logic [7:0] dat);
    sys_ctrl_pkg::ctrl_word_u w;
    logic [7:0] unused_rd;
    w.raw = dat;
    bus_xfer(1'b1, adr, dat, unused_rd);
    if (adr == sys_ctrl_pkg::REG_CTRL) begin
      w.ctl.boot_start = 1'b0;  // command bits never stick
      w.ctl.abort      = 1'b0;
      ctrl_sh = w.raw;
    end else if (adr == sys_ctrl_pkg::REG_SCRATCH) begin
      scratch_sh = dat;
    end
  endtask

  task automatic reg_check(input string name, input logic [2:0] adr);
    logic [7:0] rd;
    bus_xfer(1'b0, adr, 8'h00, rd);
    check_val(name, ref_read(adr), rd);
  endtask

  // sel 0 waits for boot ready and sel 1 for the busy led to go dark
  task automatic wait_until(input string what, input int sel);
    int n;
    n = 0;
    while (!((sel == 0) ? boot_rdy : sys_led_n[1]) && n < WAIT_LIMIT) begin
      @(posedge clk_master);
      #10;
      n++;
    end
    if (!((sel == 0) ? boot_rdy : sys_led_n[1])) begin
      $display("%s did not happen within %0d cycles", what, WAIT_LIMIT);
      $display("Test failed");
      $fatal(1, "wait timeout");
    end
  endtask

  // heartbeat led toggles every 2**HB_BIT cycles
  task automatic heartbeat_check();
    logic lvl;
    int n;
    n = 0;
    for (int k = 0; k < 2; k++) begin
      lvl = sys_led_n[0];
      n   = 0;
      while (sys_led_n[0] == lvl && n < WAIT_LIMIT) begin
        @(posedge clk_master);
        #10;
        n++;
      end
    end
    check_val("heartbeat half period", 1 << HB_BIT, n);
  endtask

  task automatic feed_byte(input logic [7:0] d);
    wait_until("boot ready", 0);
    {boot_data, boot_strb} = {d, 1'b1};
    @(posedge clk_master);
    #10;
    boot_strb = 1'b0;
  endtask

  // FPGA config port model
  initial begin
    cclk_prev = 1'b1;
    init_wait = 0;
    forever begin
      @(posedge clk_master);
      #10;
      if (!cfg_prog_n) begin
        {cfg_init_n, cfg_done} = 2'b00;  // device clears its memory
        init_wait = 3;
      end else if (!cfg_init_n) begin
        if (init_wait == 0) cfg_init_n = 1'b1;
        else init_wait--;
      end
      if (cfg_cclk && !cclk_prev) begin
        rx_bits.push_back(cfg_din);
        if (done_after != 0 && rx_bits.size() == done_after * 8) cfg_done = 1'b1;
      end
      cclk_prev = cfg_cclk;
    end
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk_master);
    $display("watchdog expired after %0d cycles, the run did not complete", WD_CYCLES);
    $display("Test failed");
    $fatal(1, "timeout");
  end

  initial begin
    logic [31:0] r;
    logic [7:0]  b;
    logic [2:0]  adr;
    int i;
    int j;
    {bus_stb, bus_we, bus_adr, bus_dat_w, boot_data, boot_strb} = '0;
    {cfg_done, user_dip, config_dip, sys_config} = '0;
    {cfg_init_n, flash_busy_n} = 2'b11;
    done_after = 0;
    apply_reset();
    check_val("reset state", 5'b11100, {cfg_prog_n, cfg_cclk, por_force_n, boot_rdy, bus_ack});
    heartbeat_check();

    // register reads and writes without boot_start or prog
    for (i = 0; i < 24; i++) begin
      r   = next_rand();
      adr = r[2:0];
      b   = (adr == sys_ctrl_pkg::REG_CTRL) ? (r[15:8] & 8'h7e) : r[15:8];
      reg_write(adr, b);
      reg_check("write readback", adr);
      check_val("user leds", {~(ctrl_sh[4] | exp_busy), ~ctrl_sh[3]}, user_led_n);
    end
    for (i = 0; i < 8; i++) reg_check("address sweep", 3'(i));

    // status, dip and write protect
    for (i = 0; i < 8; i++) begin
      r = next_rand();
      {flash_busy_n, sys_config, config_dip, user_dip} = r[16:0];
      reg_write(sys_ctrl_pkg::REG_CTRL, {2'b00, r[17], 5'b00000});
      reg_check("dip read", sys_ctrl_pkg::REG_DIP);
      reg_check("syscfg read", sys_ctrl_pkg::REG_SYSCFG);
      reg_check("status read", sys_ctrl_pkg::REG_STATUS);
      check_val("eeprom wp", user_dip[3] | ctrl_sh[5], eeprom_wp);
    end

    // serial load of a random stream
    for (i = 0; i < N_BYTES; i++) begin
      r = next_rand();
      stream.push_back(r[7:0]);
    end
    rx_bits.delete();
    done_after = N_BYTES;
    reg_write(sys_ctrl_pkg::REG_CTRL, 8'h80);
    exp_busy = 1'b1;
    reg_check("boot_start readback", sys_ctrl_pkg::REG_CTRL);
    wait_until("boot ready", 0);
    reg_check("status during load", sys_ctrl_pkg::REG_STATUS);
    check_val("busy led during load", 0, sys_led_n[1]);
    check_val("user leds during load", {~(ctrl_sh[4] | exp_busy), ~ctrl_sh[3]}, user_led_n);
    for (i = 0; i < N_BYTES; i++) feed_byte(stream[i]);
    wait_until("end of load", 1);
    exp_busy = 1'b0;
    reg_check("status after load", sys_ctrl_pkg::REG_STATUS);
    check_val("received bit count", N_BYTES * 8, rx_bits.size());
    for (i = 0; i < N_BYTES; i++) begin
      b = 8'h00;
      for (j = 0; j < 8; j++) b = {b[6:0], rx_bits[8 * i + j]};  // msb first
      check_val("serial byte", stream[i], b);
    end

    // pin ownership and then an abort in the middle of a stream
    reg_write(sys_ctrl_pkg::REG_CTRL, 8'h03);
    check_val("prog pin from register", 0, cfg_prog_n);
    check_val("init pin from register", 1, cfg_init_low);
    reg_write(sys_ctrl_pkg::REG_CTRL, 8'h00);
    done_after = 0;
    reg_write(sys_ctrl_pkg::REG_CTRL, 8'h80);
    exp_busy = 1'b1;
    r = next_rand();
    feed_byte(r[7:0]);
    reg_write(sys_ctrl_pkg::REG_CTRL, 8'h03);
    check_val("prog pin owned by loader", 1, cfg_prog_n);
    check_val("init pin owned by loader", 0, cfg_init_low);
    reg_write(sys_ctrl_pkg::REG_CTRL, 8'h43);  // abort while keeping prog and init_drive
    wait_until("end of load after abort", 1);
    exp_busy = 1'b0;
    check_val("prog pin after abort", 0, cfg_prog_n);
    check_val("init pin after abort", 1, cfg_init_low);
    check_val("cclk after abort", 1, cfg_cclk);

    // reset force latch
    apply_reset();
    reg_write(sys_ctrl_pkg::REG_CTRL, 8'h04);
    check_val("por force set", 0, por_force_n);
    reg_write(sys_ctrl_pkg::REG_CTRL, 8'h00);
    check_val("por force held", 0, por_force_n);
    apply_reset();
    check_val("por force released", 1, por_force_n);

    $display("Test passed");
    $finish;
  end

endmodule

//--- all.f
src/sys_ctrl_pkg.sv
src/cfg_if.sv
src/reg_bank.sv
src/serial_loader.sv
src/cfg_combiner.sv
src/sys_ctrl_top.sv
tests/tb_sys_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sys_ctrl
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
